//--- verilog/gamePkg.sv
package gamePkg;

	// top-left corner of an object, or the pixel being drawn
	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} point;

	// 3 bits red, 3 bits green, 2 bits blue
	typedef logic [7:0] rgb332;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic       hSync;
		logic       vSync;
		logic       blankN;
	} vgaSignals;

	// sprite sizes in pixels
	localparam int PLAYER_W = 8;
	localparam int PLAYER_H = 8;
	localparam int SHOT_W = 2;
	localparam int SHOT_H = 4;
	localparam int BIRD_W = 8;
	localparam int BIRD_H = 6;

	// motion in pixels per frame
	localparam int PLAYER_STEP = 2;
	localparam int SHOT_STEP = 3;
	localparam int BIRD_STEP = 1;

	localparam int BIRD_Y = 2;
	// frames the bird stays away after a hit
	localparam int BIRD_RESPAWN = 8;

	localparam rgb332 COLOR_BG = 8'h5c;
	localparam rgb332 COLOR_PLAYER = 8'hfc;
	localparam rgb332 COLOR_SHOT = 8'he0;
	localparam rgb332 COLOR_BIRD = 8'h03;

endpackage

//--- verilog/vgaTiming.sv
module vgaTiming #(
	parameter int H_ACTIVE = 640,
	parameter int H_TOTAL = 800,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_LEN = 96,
	parameter int V_ACTIVE = 480,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_LEN = 2
) (
	input  logic          clk,
	input  logic          rstN,
	output gamePkg::point pixel,
	output logic          hSync,
	output logic          vSync,
	output logic          blankN,
	output logic          endOfFrame
);

	logic [10:0] hCnt;
	logic [10:0] vCnt;
	logic        lineEnd;

	assign lineEnd = (hCnt == 11'(H_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hCnt <= '0;
			vCnt <= '0;
		end else begin
			if (lineEnd) begin
				hCnt <= '0;
				if (vCnt == 11'(V_TOTAL - 1))
					vCnt <= '0;
				else
					vCnt <= vCnt + 11'd1;
			end else begin
				hCnt <= hCnt + 11'd1;
			end
		end
	end

	assign pixel.x = hCnt;
	assign pixel.y = vCnt;

	// syncs are active low inside their windows
	assign hSync = !((hCnt >= H_SYNC_START) && (hCnt < H_SYNC_START + H_SYNC_LEN));
	assign vSync = !((vCnt >= V_SYNC_START) && (vCnt < V_SYNC_START + V_SYNC_LEN));
	assign blankN = (hCnt < H_ACTIVE) && (vCnt < V_ACTIVE);

	assign endOfFrame = lineEnd && (vCnt == 11'(V_TOTAL - 1));

endmodule

//--- verilog/playerLogic.sv
module playerLogic #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic          clk,
	input  logic          rstN,
	input  logic          endOfFrame,
	input  logic          left,
	input  logic          right,
	output gamePkg::point playerPos
);

	// rightmost legal corner
	localparam int X_MAX = H_ACTIVE - gamePkg::PLAYER_W;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			playerPos.x <= 11'(H_ACTIVE / 2);
			playerPos.y <= 11'(V_ACTIVE - gamePkg::PLAYER_H);
		end else if (endOfFrame) begin
			if (left && !right) begin
				if (playerPos.x < gamePkg::PLAYER_STEP)
					playerPos.x <= '0;
				else
					playerPos.x <= playerPos.x - 11'(gamePkg::PLAYER_STEP);
			end else if (right && !left) begin
				if (playerPos.x > X_MAX - gamePkg::PLAYER_STEP)
					playerPos.x <= 11'(X_MAX);
				else
					playerPos.x <= playerPos.x + 11'(gamePkg::PLAYER_STEP);
			end
		end
	end

endmodule

//--- verilog/shotPool.sv
module shotPool #(
	parameter int NUM_SHOTS = 4
) (
	input  logic                                clk,
	input  logic                                rstN,
	input  logic                                endOfFrame,
	input  logic                                shoot,
	input  gamePkg::point                       playerPos,
	input  logic          [NUM_SHOTS-1:0]       shotHit,
	output gamePkg::point [NUM_SHOTS-1:0]       shotPos,
	output logic          [NUM_SHOTS-1:0]       shotActive
);

	// shots leave from the middle of the player
	localparam int SHOT_X_OFS = (gamePkg::PLAYER_W - gamePkg::SHOT_W) / 2;

	logic [NUM_SHOTS-1:0] launch;
	gamePkg::point        launchPos;

	assign launchPos.x = playerPos.x + 11'(SHOT_X_OFS);
	assign launchPos.y = playerPos.y - 11'(gamePkg::SHOT_H);

	// lowest free slot takes the new shot, scanning down so the lowest wins
	always_comb begin
		launch = '0;
		for (int k = NUM_SHOTS - 1; k >= 0; k--) begin
			if (!shotActive[k]) begin
				launch = '0;
				launch[k] = shoot;
			end
		end
	end

	genvar k;
	generate
		for (k = 0; k < NUM_SHOTS; k++) begin : genShots
			logic          active;
			gamePkg::point pos;

			always_ff @(posedge clk) begin
				if (!rstN) begin
					active <= 1'b0;
				end else if (endOfFrame) begin
					if (launch[k])
						active <= 1'b1;
					else if (active && (shotHit[k] || pos.y < gamePkg::SHOT_STEP))
						active <= 1'b0;
				end
			end

			// a launch loads the corner and an active shot rises
			always_ff @(posedge clk) begin
				if (endOfFrame) begin
					if (launch[k])
						pos <= launchPos;
					else if (active)
						pos.y <= pos.y - 11'(gamePkg::SHOT_STEP);
				end
			end

			assign shotActive[k] = active;
			assign shotPos[k] = pos;
		end
	endgenerate

endmodule

//--- verilog/birdLogic.sv
module birdLogic #(
	parameter int H_ACTIVE = 640
) (
	input  logic          clk,
	input  logic          rstN,
	input  logic          endOfFrame,
	input  logic          birdHit,
	output gamePkg::point birdPos,
	output logic          birdAlive
);

	localparam int X_MAX = H_ACTIVE - gamePkg::BIRD_W;

	logic        [3:0]  respawnCnt;
	logic signed [10:0] nextX;

	assign nextX = birdPos.x + 11'(gamePkg::BIRD_STEP);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			birdAlive <= 1'b1;
			birdPos.x <= '0;
			birdPos.y <= 11'(gamePkg::BIRD_Y);
			respawnCnt <= '0;
		end else if (endOfFrame) begin
			if (birdHit) begin
				birdAlive <= 1'b0;
				respawnCnt <= 4'(gamePkg::BIRD_RESPAWN - 1);
			end else if (birdAlive) begin
				if (nextX > X_MAX)
					birdPos.x <= '0;
				else
					birdPos.x <= nextX;
			end else if (respawnCnt == '0) begin
				// back on the left edge
				birdAlive <= 1'b1;
				birdPos.x <= '0;
			end else begin
				respawnCnt <= respawnCnt - 4'd1;
			end
		end
	end

endmodule

//--- verilog/spriteRender.sv
module spriteRender #(
	parameter int NUM_SHOTS = 4
) (
	input  logic                                clk,
	input  logic                                rstN,
	input  gamePkg::point                       pixel,
	input  logic                                hSync,
	input  logic                                vSync,
	input  logic                                blankN,
	input  gamePkg::point                       playerPos,
	input  gamePkg::point [NUM_SHOTS-1:0]       shotPos,
	input  logic          [NUM_SHOTS-1:0]       shotActive,
	input  gamePkg::point                       birdPos,
	input  logic                                birdAlive,
	output logic                                playerReq,
	output logic          [NUM_SHOTS-1:0]       shotReq,
	output logic                                birdReq,
	output gamePkg::vgaSignals                  video
);

	gamePkg::rgb332 colour;
	gamePkg::rgb332 shown;

	// pixel inside the w by h box whose corner is tl
	function automatic logic inRect(gamePkg::point p, gamePkg::point tl, int w, int h);
		return (p.x >= tl.x) && (int'(p.x) < int'(tl.x) + w) &&
			(p.y >= tl.y) && (int'(p.y) < int'(tl.y) + h);
	endfunction

	assign playerReq = blankN &&
		inRect(pixel, playerPos, gamePkg::PLAYER_W, gamePkg::PLAYER_H);
	assign birdReq = blankN && birdAlive &&
		inRect(pixel, birdPos, gamePkg::BIRD_W, gamePkg::BIRD_H);

	always_comb begin
		for (int k = 0; k < NUM_SHOTS; k++)
			shotReq[k] = blankN && shotActive[k] &&
				inRect(pixel, shotPos[k], gamePkg::SHOT_W, gamePkg::SHOT_H);
	end

	// player in front, background at the back
	always_comb begin
		if (playerReq)
			colour = gamePkg::COLOR_PLAYER;
		else if (|shotReq)
			colour = gamePkg::COLOR_SHOT;
		else if (birdReq)
			colour = gamePkg::COLOR_BIRD;
		else
			colour = gamePkg::COLOR_BG;
	end

	assign shown = blankN ? colour : '0;

	// one register stage keeps colour and syncs together
	always_ff @(posedge clk) begin
		if (!rstN) begin
			video.red <= '0;
			video.green <= '0;
			video.blue <= '0;
			video.hSync <= 1'b1;
			video.vSync <= 1'b1;
			video.blankN <= 1'b0;
		end else begin
			video.red <= {shown[7:5], shown[7:5], shown[7:6]};
			video.green <= {shown[4:2], shown[4:2], shown[4:3]};
			video.blue <= {4{shown[1:0]}};
			video.hSync <= hSync;
			video.vSync <= vSync;
			video.blankN <= blankN;
		end
	end

endmodule

//--- verilog/collisionDetect.sv
module collisionDetect #(
	parameter int NUM_SHOTS = 4
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 endOfFrame,
	input  logic                 birdReq,
	input  logic [NUM_SHOTS-1:0] shotReq,
	output logic                 birdHit,
	output logic [NUM_SHOTS-1:0] shotHit,
	output logic [15:0]          hitCount
);

	logic [NUM_SHOTS-1:0] overlap;
	logic [NUM_SHOTS-1:0] overlapNow;
	logic [NUM_SHOTS-1:0] frameHits;

	assign overlapNow = {NUM_SHOTS{birdReq}} & shotReq;
	// include the current pixel so nothing drawn at frame end is lost
	assign frameHits = overlap | overlapNow;

	assign shotHit = endOfFrame ? frameHits : '0;
	assign birdHit = endOfFrame && (|frameHits);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			overlap <= '0;
			hitCount <= '0;
		end else if (endOfFrame) begin
			overlap <= '0;
			if (birdHit)
				hitCount <= hitCount + 16'd1;
		end else begin
			overlap <= frameHits;
		end
	end

endmodule

//--- verilog/gameTop.sv
module gameTop #(
	parameter int H_ACTIVE = 640,
	parameter int H_TOTAL = 800,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_LEN = 96,
	parameter int V_ACTIVE = 480,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_LEN = 2,
	parameter int NUM_SHOTS = 4
) (
	input  logic               clk,
	input  logic               rstN,
	input  logic [3:0]         keys,
	output gamePkg::vgaSignals video,
	output logic [15:0]        hitCount
);

	gamePkg::point                 pixel;
	logic                          hSyncRaw;
	logic                          vSyncRaw;
	logic                          blankNRaw;
	logic                          endOfFrame;
	gamePkg::point                 playerPos;
	gamePkg::point [NUM_SHOTS-1:0] shotPos;
	logic          [NUM_SHOTS-1:0] shotActive;
	gamePkg::point                 birdPos;
	logic                          birdAlive;
	logic          [NUM_SHOTS-1:0] shotReq;
	logic                          birdReq;
	logic                          birdHit;
	logic          [NUM_SHOTS-1:0] shotHit;
	logic                          left;
	logic                          right;
	logic                          shoot;

	// push keys are active low
	assign right = !keys[1];
	assign shoot = !keys[2];
	assign left = !keys[3];

	vgaTiming #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
	) iVgaTiming (
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.hSync(hSyncRaw),
		.vSync(vSyncRaw),
		.blankN(blankNRaw),
		.endOfFrame(endOfFrame)
	);

	playerLogic #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) iPlayerLogic (
		.clk(clk),
		.rstN(rstN),
		.endOfFrame(endOfFrame),
		.left(left),
		.right(right),
		.playerPos(playerPos)
	);

	shotPool #(.NUM_SHOTS(NUM_SHOTS)) iShotPool (
		.clk(clk),
		.rstN(rstN),
		.endOfFrame(endOfFrame),
		.shoot(shoot),
		.playerPos(playerPos),
		.shotHit(shotHit),
		.shotPos(shotPos),
		.shotActive(shotActive)
	);

	birdLogic #(.H_ACTIVE(H_ACTIVE)) iBirdLogic (
		.clk(clk),
		.rstN(rstN),
		.endOfFrame(endOfFrame),
		.birdHit(birdHit),
		.birdPos(birdPos),
		.birdAlive(birdAlive)
	);

	spriteRender #(.NUM_SHOTS(NUM_SHOTS)) iSpriteRender (
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.hSync(hSyncRaw),
		.vSync(vSyncRaw),
		.blankN(blankNRaw),
		.playerPos(playerPos),
		.shotPos(shotPos),
		.shotActive(shotActive),
		.birdPos(birdPos),
		.birdAlive(birdAlive),
		// player overlap is not scored, only drawn
		.playerReq(),
		.shotReq(shotReq),
		.birdReq(birdReq),
		.video(video)
	);

	collisionDetect #(.NUM_SHOTS(NUM_SHOTS)) iCollisionDetect (
		.clk(clk),
		.rstN(rstN),
		.endOfFrame(endOfFrame),
		.birdReq(birdReq),
		.shotReq(shotReq),
		.birdHit(birdHit),
		.shotHit(shotHit),
		.hitCount(hitCount)
	);

endmodule

//--- tb/clockGen.sv
module clockGen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 1ps;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// release on a falling edge, after RESET_CYCLES rising edges
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

//--- tb/vgaTiming_chk.sv
module vgaTimingChk #(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC_LEN = 96
) (
	input logic          clk,
	input logic          rstN,
	input gamePkg::point pixel,
	input logic          hSync,
	input logic          endOfFrame
);
	timeunit 1ns;
	timeprecision 1ps;

	// cycles hSync has been low so far in this pulse
	int lowLen = 0;

	always @(posedge clk) begin
		if (!rstN || hSync)
			lowLen <= 0;
		else
			lowLen <= lowLen + 1;
	end

	syncWidth: assert property (@(posedge clk) disable iff (!rstN)
		$rose(hSync) |-> (lowLen == H_SYNC_LEN))
		else $error("hSync low pulse has the wrong width");

	frameWrap: assert property (@(posedge clk) disable iff (!rstN)
		endOfFrame |=> (pixel.x == 0 && pixel.y == 0))
		else $error("pixel counter did not return to the origin after frame end");

	lineBound: assert property (@(posedge clk) disable iff (!rstN)
		pixel.x < H_TOTAL)
		else $error("horizontal counter ran past the line length");

endmodule

//--- tb/gameTb.sv
module gameTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE = 48;
	localparam int H_TOTAL = 56;
	localparam int H_SYNC_START = 50;
	localparam int H_SYNC_LEN = 2;
	localparam int V_ACTIVE = 32;
	localparam int V_TOTAL = 36;
	localparam int V_SYNC_START = 33;
	localparam int V_SYNC_LEN = 1;
	localparam int NUM_SHOTS = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_FRAMES = 160;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int CYCLE_LIMIT = 200 * FRAME_CYCLES + RESET_CYCLES;
	// frames per phase of the left/right bias on the keys
	localparam int PHASE_FRAMES = 40;
	localparam int SHOT_X_OFFSET = 3;

	logic               clk;
	logic               rstN;
	logic [3:0]         keys;
	gamePkg::vgaSignals video;
	logic [15:0]        hitCount;

	// reference game state
	int pX;
	int pY;
	int shotX[NUM_SHOTS];
	int shotY[NUM_SHOTS];
	bit shotOn[NUM_SHOTS];
	bit hitSeen[NUM_SHOTS];
	int birdX;
	bit birdOn;
	int birdWait;
	int hitTotal;

	int seed = 1;
	int errorCount = 0;
	int cycleCount = 0;
	int frame;
	int hm;
	int vm;

	clockGen #(.RESET_CYCLES(RESET_CYCLES)) iClockGen (.clk(clk), .rstN(rstN));

	gameTop #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
		.NUM_SHOTS(NUM_SHOTS)
	) i_gameTop (
		.clk(clk),
		.rstN(rstN),
		.keys(keys),
		.video(video),
		.hitCount(hitCount)
	);

	bind vgaTiming vgaTimingChk #(.H_TOTAL(H_TOTAL), .H_SYNC_LEN(H_SYNC_LEN)) iTimingChk (
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.hSync(hSync),
		.endOfFrame(endOfFrame)
	);

	function automatic bit inBox(int x, int y, int bx, int by, int w, int h);
		return (x >= bx) && (x < bx + w) && (y >= by) && (y < by + h);
	endfunction

	function automatic bit shotCovers(int k, int x, int y);
		return shotOn[k] && inBox(x, y, shotX[k], shotY[k], gamePkg::SHOT_W, gamePkg::SHOT_H);
	endfunction

	function automatic bit birdCovers(int x, int y);
		return birdOn && inBox(x, y, birdX, gamePkg::BIRD_Y, gamePkg::BIRD_W, gamePkg::BIRD_H);
	endfunction

	// what the screen should show one cycle after the counter sat at (x, y)
	function automatic gamePkg::vgaSignals expectedVideo(int x, int y);
		gamePkg::vgaSignals v;
		logic [7:0]         c;
		bit                 active;
		bit                 shotHere;
		active = (x < H_ACTIVE) && (y < V_ACTIVE);
		shotHere = 1'b0;
		for (int k = 0; k < NUM_SHOTS; k++)
			if (shotCovers(k, x, y))
				shotHere = 1'b1;
		if (!active)
			c = 8'h00;
		else if (inBox(x, y, pX, pY, gamePkg::PLAYER_W, gamePkg::PLAYER_H))
			c = gamePkg::COLOR_PLAYER;
		else if (shotHere)
			c = gamePkg::COLOR_SHOT;
		else if (birdCovers(x, y))
			c = gamePkg::COLOR_BIRD;
		else
			c = gamePkg::COLOR_BG;
		v.red = {c[7:5], c[7:5], c[7:6]};
		v.green = {c[4:2], c[4:2], c[4:3]};
		v.blue = {c[1:0], c[1:0], c[1:0], c[1:0]};
		v.hSync = !((x >= H_SYNC_START) && (x < H_SYNC_START + H_SYNC_LEN));
		v.vSync = !((y >= V_SYNC_START) && (y < V_SYNC_START + V_SYNC_LEN));
		v.blankN = active;
		return v;
	endfunction

	task automatic resetModel();
		pX = H_ACTIVE / 2;
		pY = V_ACTIVE - gamePkg::PLAYER_H;
		for (int k = 0; k < NUM_SHOTS; k++) begin
			shotOn[k] = 1'b0;
			hitSeen[k] = 1'b0;
			shotX[k] = 0;
			shotY[k] = 0;
		end
		birdX = 0;
		birdOn = 1'b1;
		birdWait = 0;
		hitTotal = 0;
	endtask

	// bird and shot drawn on the same active pixel
	task automatic notePixel(int x, int y);
		if (x < H_ACTIVE && y < V_ACTIVE && birdCovers(x, y))
			for (int k = 0; k < NUM_SHOTS; k++)
				if (shotCovers(k, x, y))
					hitSeen[k] = 1'b1;
	endtask

	// model update at frame end with the keys held at this edge
	task automatic endFrame();
		bit anyHit;
		bit goLeft;
		bit goRight;
		bit fire;
		int slot;
		anyHit = 1'b0;
		goRight = !keys[1];
		fire = !keys[2];
		goLeft = !keys[3];
		slot = -1;
		for (int k = 0; k < NUM_SHOTS; k++) begin
			if (hitSeen[k])
				anyHit = 1'b1;
			if (fire && !shotOn[k] && slot < 0)
				slot = k;
		end
		// a new shot starts from where the player stood this frame
		for (int k = 0; k < NUM_SHOTS; k++) begin
			if (k == slot) begin
				shotOn[k] = 1'b1;
				shotX[k] = pX + SHOT_X_OFFSET;
				shotY[k] = pY - gamePkg::SHOT_H;
			end else if (shotOn[k]) begin
				if (hitSeen[k] || shotY[k] < gamePkg::SHOT_STEP)
					shotOn[k] = 1'b0;
				else
					shotY[k] = shotY[k] - gamePkg::SHOT_STEP;
			end
			hitSeen[k] = 1'b0;
		end
		if (goLeft && !goRight)
			pX = (pX - gamePkg::PLAYER_STEP < 0) ? 0 : pX - gamePkg::PLAYER_STEP;
		else if (goRight && !goLeft)
			pX = (pX + gamePkg::PLAYER_STEP > H_ACTIVE - gamePkg::PLAYER_W) ?
				H_ACTIVE - gamePkg::PLAYER_W : pX + gamePkg::PLAYER_STEP;
		if (anyHit) begin
			birdOn = 1'b0;
			birdWait = gamePkg::BIRD_RESPAWN;
			hitTotal++;
		end else if (birdOn) begin
			birdX = birdX + gamePkg::BIRD_STEP;
			if (birdX > H_ACTIVE - gamePkg::BIRD_W)
				birdX = 0;
		end else begin
			birdWait--;
			if (birdWait == 0) begin
				birdOn = 1'b1;
				birdX = 0;
			end
		end
	endtask

	task automatic reportMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
		errorCount++;
		$display("MISMATCH %s: expected %h, actual %h (frame %0d, x %0d, y %0d)",
			testName, expected, actual, frame, hm, vm);
		$display("Finished with errors");
		$fatal(1, "stopped at the first error");
	endtask

	// random keys biased toward one side per phase so the player reaches each edge
	task automatic pickKeys();
		logic [31:0] r;
		r = $random(seed);
		keys = r[3:0];
		// every eighth frame the keys stay fully random
		if (frame % 8 != 7) begin
			if ((frame / PHASE_FRAMES) % 2 == 0) begin
				keys[1] = 1'b0;
				keys[3] = !(r[4] && r[5]);
			end else begin
				keys[3] = 1'b0;
				keys[1] = !(r[4] && r[5]);
			end
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	initial begin
		gamePkg::vgaSignals expV;
		bit                 eof;
		keys = 4'hf;
		frame = 0;
		hm = 0;
		vm = 0;
		resetModel();
		@(posedge rstN);
		assert ({video.hSync, video.vSync, video.blankN} == 3'b110)
			else reportMismatch("reset", 32'b110, {video.hSync, video.vSync, video.blankN});
		pickKeys();
		while (frame < NUM_FRAMES) begin
			expV = expectedVideo(hm, vm);
			notePixel(hm, vm);
			eof = (hm == H_TOTAL - 1) && (vm == V_TOTAL - 1);
			@(negedge clk);
			assert ({video.hSync, video.vSync, video.blankN} ==
				{expV.hSync, expV.vSync, expV.blankN})
				else reportMismatch("raster", {expV.hSync, expV.vSync, expV.blankN},
					{video.hSync, video.vSync, video.blankN});
			assert ({video.red, video.green, video.blue} == {expV.red, expV.green, expV.blue})
				else reportMismatch("pixel", {expV.red, expV.green, expV.blue},
					{video.red, video.green, video.blue});
			if (eof) begin
				endFrame();
				frame++;
				pickKeys();
			end
			assert (hitCount == 16'(hitTotal))
				else reportMismatch("hitCount", hitTotal, hitCount);
			if (hm == H_TOTAL - 1) begin
				hm = 0;
				vm = (vm == V_TOTAL - 1) ? 0 : vm + 1;
			end else begin
				hm++;
			end
		end
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- sources.f
verilog/gamePkg.sv
verilog/vgaTiming.sv
verilog/playerLogic.sv
verilog/shotPool.sv
verilog/birdLogic.sv
verilog/spriteRender.sv
verilog/collisionDetect.sv
verilog/gameTop.sv
tb/clockGen.sv
tb/vgaTiming_chk.sv
tb/gameTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the game core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module gameTb -f sources.f -o gameSim

status=0
./obj_dir/gameSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log || [ "$status" -ne 0 ] \
	|| ! grep -q "Finished with no errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
